//--- design/cd_data_streamer.sv
// CD data byte streamer
module cd_data_streamer #(
	parameter int CD_LEN_W = pce_load_pkg::CD_LEN_W_DEFAULT
) (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  cd_active,
	input  logic                                  ioctl_wr,
	input  logic [pce_load_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	output logic [7:0]                            cd_byte,
	output logic                                  cd_wr,
	output logic                                  cd_data_mode
);
	import pce_load_pkg::*;

	cd_state_t state;
	logic cd_active_q;
	logic [CD_LEN_W-1:0] cd_len;
	logic [CD_LEN_W-1:0] cd_cnt;
	logic [IOCTL_DATA_W-1:0] cd_word;
	logic word_wr;

	assign word_wr = cd_active && cd_active_q && ioctl_wr;

	// High byte only during the second strobe
	assign cd_byte = state == CD_BYTE_HIGH ? cd_word[15:8] : cd_word[7:0];

	////////////////////////////////////////
	// Header and byte phases
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cd_active_q <= 1'b0;
			state <= CD_HEADER;
			cd_wr <= 1'b0;
			cd_len <= '0;
			cd_cnt <= '0;
			cd_data_mode <= 1'b0;
		end else begin
			cd_active_q <= cd_active;
			if (cd_active && !cd_active_q) begin
				state <= CD_HEADER;
				cd_wr <= 1'b0;
				cd_cnt <= '0;
			end else begin
				case (state)
					CD_HEADER: begin
						if (word_wr) begin
							cd_data_mode <= ioctl_dout[15];
							cd_len <= ioctl_dout[CD_LEN_W-1:0];
							cd_cnt <= '0;
							state <= CD_IDLE;
						end
					end
					CD_IDLE: begin
						// Words past the length are dropped
						if (word_wr && cd_cnt < cd_len) begin
							cd_wr <= 1'b1;
							state <= CD_BYTE_LOW;
						end
					end
					CD_BYTE_LOW: begin
						cd_wr <= 1'b0;
						cd_cnt <= cd_cnt + 1'b1;
						// Odd length ends on a low byte
						state <= cd_cnt + 1'b1 >= cd_len ? CD_IDLE : CD_BYTE_HIGH;
					end
					CD_BYTE_HIGH: begin
						if (!cd_wr) begin
							cd_wr <= 1'b1;
						end else begin
							cd_wr <= 1'b0;
							cd_cnt <= cd_cnt + 1'b1;
							state <= CD_IDLE;
						end
					end
					default: state <= CD_HEADER;
				endcase
			end
		end
	end

	// Data word kept for both strobes
	always_ff @(posedge clk_sys) begin
		if (state == CD_IDLE && word_wr) begin
			cd_word <= ioctl_dout;
		end
	end

endmodule

//--- design/cheat_code_loader.sv
// Cheat code record assembler
module cheat_code_loader (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  code_active,
	input  logic                                  ioctl_wr,
	input  logic [pce_load_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [pce_load_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	output logic                                  code_strobe,
	output logic [pce_load_pkg::CODE_WORD_W-1:0]  code_flags,
	output logic [pce_load_pkg::CODE_WORD_W-1:0]  code_addr,
	output logic [pce_load_pkg::CODE_WORD_W-1:0]  code_compare,
	output logic [pce_load_pkg::CODE_WORD_W-1:0]  code_replace
);
	import pce_load_pkg::*;

	logic code_wr;

	assign code_wr = code_active && ioctl_wr;

	// Record complete once the top word of replace lands
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_strobe <= 1'b0;
		end else begin
			code_strobe <= code_wr && ioctl_addr[3:0] == 4'd14;
		end
	end

	////////////////////////////////////////
	// Field slots, low word first
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0: code_flags[IOCTL_DATA_W-1:0] <= ioctl_dout;
				4'd2: code_flags[CODE_WORD_W-1:IOCTL_DATA_W] <= ioctl_dout;
				4'd4: code_addr[IOCTL_DATA_W-1:0] <= ioctl_dout;
				4'd6: code_addr[CODE_WORD_W-1:IOCTL_DATA_W] <= ioctl_dout;
				4'd8: code_compare[IOCTL_DATA_W-1:0] <= ioctl_dout;
				4'd10: code_compare[CODE_WORD_W-1:IOCTL_DATA_W] <= ioctl_dout;
				4'd12: code_replace[IOCTL_DATA_W-1:0] <= ioctl_dout;
				4'd14: code_replace[CODE_WORD_W-1:IOCTL_DATA_W] <= ioctl_dout;
				default: ;
			endcase
		end
	end

endmodule

//--- design/pce_load_pkg.sv
// PC Engine loader definitions
package pce_load_pkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////

	localparam int IOCTL_DATA_W = 16;
	localparam int IOCTL_ADDR_W = 25;
	localparam int ROM_ADDR_W = 24;
	localparam int CODE_WORD_W = 32;

	// Byte length field of the CD data header
	localparam int CD_LEN_W_DEFAULT = 15;

	////////////////////////////////////////
	// Populous signature
	////////////////////////////////////////

	// 16-byte lines, one per bank
	localparam logic [ROM_ADDR_W-5:0] POP_BANK0_LINE = 'h1f2;
	localparam logic [ROM_ADDR_W-5:0] POP_BANK1_LINE = 'h212;

	// Expected words at line offsets 6, 8, 10 and 12
	localparam logic [IOCTL_DATA_W-1:0] POP_SIG_0 = 'h4F50;
	localparam logic [IOCTL_DATA_W-1:0] POP_SIG_1 = 'h5550;
	localparam logic [IOCTL_DATA_W-1:0] POP_SIG_2 = 'h4F4C;
	localparam logic [IOCTL_DATA_W-1:0] POP_SIG_3 = 'h5355;

	////////////////////////////////////////
	// State and kind encodings
	////////////////////////////////////////

	typedef enum logic {ROM_IDLE, ROM_WAIT_ACK} rom_state_t;

	typedef enum logic [1:0] {CD_HEADER, CD_IDLE, CD_BYTE_LOW, CD_BYTE_HIGH} cd_state_t;

	typedef enum logic [1:0] {DL_NONE, DL_CART, DL_CD_DATA, DL_CODE} download_kind_t;

endpackage

//--- design/pce_loader_top.sv
// PC Engine download front end
module pce_loader_top #(
	parameter int CD_LEN_W = pce_load_pkg::CD_LEN_W_DEFAULT
) (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  ioctl_download,
	input  logic [7:0]                            ioctl_index,
	input  logic                                  ioctl_wr,
	input  logic [pce_load_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [pce_load_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic                                  data_swap,
	input  logic                                  mem_wr_ack,
	output logic                                  rom_wr_req,
	output logic [pce_load_pkg::ROM_ADDR_W-1:0]   rom_addr,
	output logic [pce_load_pkg::IOCTL_DATA_W-1:0] rom_data,
	output logic [11:0]                           rom_size,
	output logic                                  ioctl_wait,
	output logic                                  sgx,
	output logic [1:0]                            populous,
	output logic                                  code_strobe,
	output logic [pce_load_pkg::CODE_WORD_W-1:0]  code_flags,
	output logic [pce_load_pkg::CODE_WORD_W-1:0]  code_addr,
	output logic [pce_load_pkg::CODE_WORD_W-1:0]  code_compare,
	output logic [pce_load_pkg::CODE_WORD_W-1:0]  code_replace,
	output logic [7:0]                            cd_byte,
	output logic                                  cd_wr,
	output logic                                  cd_data_mode
);
	import pce_load_pkg::*;

	download_kind_t download_kind;
	logic cart_active;
	logic cd_active;
	logic code_active;

	////////////////////////////////////////
	// Download kind decode
	////////////////////////////////////////

	always_comb begin
		download_kind = DL_NONE;
		if (&ioctl_index) begin
			download_kind = DL_CODE;
		end else if (ioctl_index[5:0] <= 6'd1) begin
			download_kind = DL_CART;
		end else if (ioctl_index[5:0] == 6'd2) begin
			download_kind = DL_CD_DATA;
		end
	end

	assign cart_active = ioctl_download && download_kind == DL_CART;
	assign cd_active = ioctl_download && download_kind == DL_CD_DATA;
	assign code_active = ioctl_download && download_kind == DL_CODE;

	////////////////////////////////////////
	// Loaders
	////////////////////////////////////////

	// Index bit 0 selects the SuperGrafx variant
	rom_loader rom_loader_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.cart_active(cart_active),
		.console_sel(ioctl_index[0]),
		.ioctl_wr(ioctl_wr),
		.ioctl_dout(ioctl_dout),
		.data_swap(data_swap),
		.mem_wr_ack(mem_wr_ack),
		.rom_wr_req(rom_wr_req),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.rom_size(rom_size),
		.ioctl_wait(ioctl_wait),
		.sgx(sgx),
		.populous(populous)
	);

	cheat_code_loader cheat_code_loader_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.code_active(code_active),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.code_strobe(code_strobe),
		.code_flags(code_flags),
		.code_addr(code_addr),
		.code_compare(code_compare),
		.code_replace(code_replace)
	);

	cd_data_streamer #(
		.CD_LEN_W(CD_LEN_W)
	) cd_data_streamer_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.cd_active(cd_active),
		.ioctl_wr(ioctl_wr),
		.ioctl_dout(ioctl_dout),
		.cd_byte(cd_byte),
		.cd_wr(cd_wr),
		.cd_data_mode(cd_data_mode)
	);

endmodule

//--- design/rom_loader.sv
// Cartridge ROM loader
module rom_loader (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  cart_active,
	input  logic                                  console_sel,
	input  logic                                  ioctl_wr,
	input  logic [pce_load_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic                                  data_swap,
	input  logic                                  mem_wr_ack,
	output logic                                  rom_wr_req,
	output logic [pce_load_pkg::ROM_ADDR_W-1:0]   rom_addr,
	output logic [pce_load_pkg::IOCTL_DATA_W-1:0] rom_data,
	output logic [pce_load_pkg::ROM_ADDR_W-13:0]  rom_size,
	output logic                                  ioctl_wait,
	output logic                                  sgx,
	output logic [1:0]                            populous
);
	import pce_load_pkg::*;

	rom_state_t state;
	logic cart_active_q;
	logic accept;
	logic [IOCTL_DATA_W-1:0] swapped;
	logic [IOCTL_DATA_W-1:0] expected;
	logic sig_line;
	logic sig_slot;

	// Mirror the bit order inside each byte
	function automatic logic [IOCTL_DATA_W-1:0] reverse_bytes(
		input logic [IOCTL_DATA_W-1:0] w
	);
		logic [IOCTL_DATA_W-1:0] r;
		for (int i = 0; i < IOCTL_DATA_W; i++) begin
			r[(i / 8) * 8 + 7 - (i % 8)] = w[i];
		end
		return r;
	endfunction

	assign swapped = data_swap ? reverse_bytes(ioctl_dout) : ioctl_dout;

	// Only one word in flight; host holds off while ioctl_wait is up
	assign accept = ioctl_wr && cart_active && cart_active_q && state == ROM_IDLE;
	assign ioctl_wait = state == ROM_WAIT_ACK;
	assign rom_size = rom_addr[ROM_ADDR_W-1:12];

	////////////////////////////////////////
	// Signature check
	////////////////////////////////////////

	assign sig_line = rom_addr[ROM_ADDR_W-1:4] == POP_BANK0_LINE ||
		rom_addr[ROM_ADDR_W-1:4] == POP_BANK1_LINE;

	always_comb begin
		sig_slot = 1'b1;
		expected = POP_SIG_0;
		case (rom_addr[3:0])
			4'd6: expected = POP_SIG_0;
			4'd8: expected = POP_SIG_1;
			4'd10: expected = POP_SIG_2;
			4'd12: expected = POP_SIG_3;
			default: sig_slot = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// Toggle handshake
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_active_q <= 1'b0;
			state <= ROM_IDLE;
			rom_wr_req <= 1'b0;
			rom_addr <= '0;
			sgx <= 1'b0;
			populous <= 2'b00;
		end else begin
			cart_active_q <= cart_active;
			if (cart_active && !cart_active_q) begin
				// New download starts from address 0
				rom_addr <= '0;
				populous <= 2'b11;
				sgx <= console_sel;
			end else begin
				case (state)
					ROM_IDLE: begin
						if (accept) begin
							state <= ROM_WAIT_ACK;
							rom_wr_req <= ~rom_wr_req;
							// Bank picked by address bit 13
							if (sig_line && sig_slot && swapped != expected) begin
								populous[rom_addr[13]] <= 1'b0;
							end
						end
					end
					ROM_WAIT_ACK: begin
						if (mem_wr_ack == rom_wr_req) begin
							state <= ROM_IDLE;
							rom_addr <= rom_addr + 2'd2;
						end
					end
					default: state <= ROM_IDLE;
				endcase
			end
		end
	end

	// Word held for the back end until the acknowledge
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			rom_data <= swapped;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module pce_loader_tb -o pce_loader_sim &&
./obj_dir/pce_loader_sim +verilator+error+limit+1000 | tee /dev/stderr |
	grep -qx "Test passed" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }

//--- sources.f
design/pce_load_pkg.sv
design/rom_loader.sv
design/cheat_code_loader.sv
design/cd_data_streamer.sv
design/pce_loader_top.sv
tb/clock_gen.sv
tb/pce_loader_props.sv
tb/pce_loader_tb.sv

//--- tb/clock_gen.sv
// Testbench clock and reset
module clock_gen #(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Released just after an edge, like the rest of the stimulus
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;
	end

endmodule

//--- tb/pce_loader_props.sv
// Loader assertion checks
module pce_loader_props #(
	parameter int CD_LEN_W = pce_load_pkg::CD_LEN_W_DEFAULT
) (
	input logic                                  clk_sys,
	input logic                                  reset,
	input logic                                  ioctl_download,
	input logic [7:0]                            ioctl_index,
	input logic                                  ioctl_wr,
	input logic [pce_load_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input logic [pce_load_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input logic                                  data_swap,
	input logic                                  mem_wr_ack,
	input logic                                  rom_wr_req,
	input logic [pce_load_pkg::ROM_ADDR_W-1:0]   rom_addr,
	input logic [pce_load_pkg::IOCTL_DATA_W-1:0] rom_data,
	input logic [11:0]                           rom_size,
	input logic                                  ioctl_wait,
	input logic                                  sgx,
	input logic [1:0]                            populous,
	input logic                                  code_strobe,
	input logic [pce_load_pkg::CODE_WORD_W-1:0]  code_flags,
	input logic [pce_load_pkg::CODE_WORD_W-1:0]  code_addr,
	input logic [pce_load_pkg::CODE_WORD_W-1:0]  code_compare,
	input logic [pce_load_pkg::CODE_WORD_W-1:0]  code_replace,
	input logic [7:0]                            cd_byte,
	input logic                                  cd_wr,
	input logic                                  cd_data_mode
);
	import pce_load_pkg::*;

	localparam logic [ROM_ADDR_W-1:0] ADDR_STEP = 2;

	int fail_count = 0;
	logic cart_dl;
	logic cart_dl_q;
	logic cart_wr;
	logic code_wr;
	logic cd_dl;
	logic cd_dl_q;
	logic cd_word_wr;
	logic sig_hit;
	logic [15:0] wr_word;
	logic [1:0] pop_exp;
	logic [ROM_ADDR_W-1:0] bytes_sent;
	logic [15:0] slot_word [8];
	logic hdr_seen;
	logic hdr_mode;
	int hdr_len;
	logic [15:0] cd_words [64];
	int word_cnt;
	int pulse_cnt;
	logic [7:0] exp_byte;

	// Each byte mirrored end to end
	function automatic logic [15:0] mirror_bytes(input logic [15:0] w);
		logic [15:0] m;
		for (int b = 0; b < 2; b++) begin
			for (int j = 0; j < 8; j++) begin
				m[b * 8 + j] = w[b * 8 + 7 - j];
			end
		end
		return m;
	endfunction

	function automatic logic [15:0] sig_expected(input logic [3:0] offset);
		case (offset)
			4'd6: return POP_SIG_0;
			4'd8: return POP_SIG_1;
			4'd10: return POP_SIG_2;
			default: return POP_SIG_3;
		endcase
	endfunction

	////////////////////////////////////////
	// Reference model of the host side
	////////////////////////////////////////

	assign cart_dl = ioctl_download && ioctl_index[5:0] <= 6'd1;
	assign cd_dl = ioctl_download && ioctl_index[5:0] == 6'd2;
	assign cart_wr = cart_dl && cart_dl_q && ioctl_wr;
	assign cd_word_wr = cd_dl && cd_dl_q && ioctl_wr;
	assign code_wr = ioctl_download && &ioctl_index && ioctl_wr;
	assign wr_word = data_swap ? mirror_bytes(ioctl_dout) : ioctl_dout;
	assign sig_hit = (ioctl_addr[23:4] == POP_BANK0_LINE || ioctl_addr[23:4] == POP_BANK1_LINE)
		&& ioctl_addr[3:0] inside {4'd6, 4'd8, 4'd10, 4'd12};
	assign exp_byte = pulse_cnt[0] ? cd_words[pulse_cnt[6:1]][15:8] : cd_words[pulse_cnt[6:1]][7:0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q <= 1'b0;
			cd_dl_q <= 1'b0;
			pop_exp <= 2'b00;
			bytes_sent <= '0;
			hdr_seen <= 1'b0;
			word_cnt <= 0;
			pulse_cnt <= 0;
		end else begin
			cart_dl_q <= cart_dl;
			cd_dl_q <= cd_dl;
			if (cart_dl && !cart_dl_q) begin
				pop_exp <= 2'b11;
				bytes_sent <= '0;
			end else if (cart_wr) begin
				// Every host word moves the ROM address on by one word
				bytes_sent <= bytes_sent + ADDR_STEP;
				if (sig_hit && wr_word != sig_expected(ioctl_addr[3:0])) begin
					pop_exp[ioctl_addr[13]] <= 1'b0;
				end
			end
			if (code_wr) begin
				slot_word[ioctl_addr[3:1]] <= ioctl_dout;
			end
			if (cd_dl && !cd_dl_q) begin
				hdr_seen <= 1'b0;
				word_cnt <= 0;
				pulse_cnt <= 0;
			end else begin
				if (cd_word_wr && !hdr_seen) begin
					hdr_seen <= 1'b1;
					hdr_mode <= ioctl_dout[15];
					hdr_len <= int'(ioctl_dout[CD_LEN_W-1:0]);
				end else if (cd_word_wr && word_cnt < 64) begin
					cd_words[word_cnt[5:0]] <= ioctl_dout;
					word_cnt <= word_cnt + 1;
				end
				if (cd_wr) begin
					pulse_cnt <= pulse_cnt + 1;
				end
			end
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	a_reset_quiet: assert property (@(posedge clk_sys)
		reset |=> !ioctl_wait && !cd_wr && !code_strobe)
		else begin
			$error("CHECK FAILED at %0t: outputs active after reset", $time);
			fail_count = fail_count + 1;
		end

	a_wait_holds: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wait && rom_wr_req != mem_wr_ack |=> ioctl_wait && $stable(rom_addr))
		else begin
			$error("CHECK FAILED at %0t: wait released or address moved early", $time);
			fail_count = fail_count + 1;
		end

	a_ack_done: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wait && rom_wr_req == mem_wr_ack |=>
		!ioctl_wait && rom_addr == $past(rom_addr) + ADDR_STEP)
		else begin
			$error("CHECK FAILED at %0t: acknowledge did not end the write", $time);
			fail_count = fail_count + 1;
		end

	a_req_follows: assert property (@(posedge clk_sys) disable iff (reset)
		cart_wr |=> ioctl_wait && rom_wr_req != $past(rom_wr_req))
		else begin
			$error("CHECK FAILED at %0t: no request toggle after ROM word", $time);
			fail_count = fail_count + 1;
		end

	a_rom_data: assert property (@(posedge clk_sys) disable iff (reset)
		cart_wr |=> rom_data == $past(wr_word))
		else begin
			$error("CHECK FAILED at %0t: rom_data %h is wrong", $time, rom_data);
			fail_count = fail_count + 1;
		end

	a_rom_size: assert property (@(posedge clk_sys) disable iff (reset)
		cart_dl && cart_dl_q && !ioctl_wait |->
		rom_addr == bytes_sent && rom_size == bytes_sent[ROM_ADDR_W-1:12])
		else begin
			$error("CHECK FAILED at %0t: rom_addr %h rom_size %h after %h bytes", $time,
				rom_addr, rom_size, bytes_sent);
			fail_count = fail_count + 1;
		end

	a_sgx: assert property (@(posedge clk_sys) disable iff (reset)
		cart_dl && !cart_dl_q |=> sgx == $past(ioctl_index[0]))
		else begin
			$error("CHECK FAILED at %0t: sgx does not follow index bit 0", $time);
			fail_count = fail_count + 1;
		end

	a_populous: assert property (@(posedge clk_sys) disable iff (reset)
		cart_dl && cart_dl_q |-> populous == pop_exp)
		else begin
			$error("CHECK FAILED at %0t: populous %b, expected %b", $time, populous, pop_exp);
			fail_count = fail_count + 1;
		end

	a_code_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		code_wr && ioctl_addr[3:0] == 4'd14 |=> code_strobe)
		else begin
			$error("CHECK FAILED at %0t: missing code_strobe", $time);
			fail_count = fail_count + 1;
		end

	a_code_single: assert property (@(posedge clk_sys) disable iff (reset)
		code_strobe |=> !code_strobe)
		else begin
			$error("CHECK FAILED at %0t: code_strobe longer than one cycle", $time);
			fail_count = fail_count + 1;
		end

	a_code_fields: assert property (@(posedge clk_sys) disable iff (reset)
		code_strobe |-> code_flags == {slot_word[1], slot_word[0]}
		&& code_addr == {slot_word[3], slot_word[2]}
		&& code_compare == {slot_word[5], slot_word[4]}
		&& code_replace == {slot_word[7], slot_word[6]})
		else begin
			$error("CHECK FAILED at %0t: cheat record fields wrong", $time);
			fail_count = fail_count + 1;
		end

	a_cd_byte: assert property (@(posedge clk_sys) disable iff (reset)
		cd_wr |-> cd_byte == exp_byte && pulse_cnt < hdr_len)
		else begin
			$error("CHECK FAILED at %0t: cd_byte %h, expected %h", $time, cd_byte, exp_byte);
			fail_count = fail_count + 1;
		end

	a_cd_count: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(cd_dl) |-> pulse_cnt == hdr_len)
		else begin
			$error("CHECK FAILED at %0t: %0d cd_wr pulses for length %0d", $time,
				pulse_cnt, hdr_len);
			fail_count = fail_count + 1;
		end

	a_cd_mode: assert property (@(posedge clk_sys) disable iff (reset)
		cd_dl && hdr_seen |-> cd_data_mode == hdr_mode)
		else begin
			$error("CHECK FAILED at %0t: cd_data_mode differs from header", $time);
			fail_count = fail_count + 1;
		end

endmodule

bind pce_loader_top pce_loader_props #(
	.CD_LEN_W(CD_LEN_W)
) props_i (
	.clk_sys(clk_sys),
	.reset(reset),
	.ioctl_download(ioctl_download),
	.ioctl_index(ioctl_index),
	.ioctl_wr(ioctl_wr),
	.ioctl_addr(ioctl_addr),
	.ioctl_dout(ioctl_dout),
	.data_swap(data_swap),
	.mem_wr_ack(mem_wr_ack),
	.rom_wr_req(rom_wr_req),
	.rom_addr(rom_addr),
	.rom_data(rom_data),
	.rom_size(rom_size),
	.ioctl_wait(ioctl_wait),
	.sgx(sgx),
	.populous(populous),
	.code_strobe(code_strobe),
	.code_flags(code_flags),
	.code_addr(code_addr),
	.code_compare(code_compare),
	.code_replace(code_replace),
	.cd_byte(cd_byte),
	.cd_wr(cd_wr),
	.cd_data_mode(cd_data_mode)
);

//--- tb/pce_loader_tb.sv
// PC Engine loader testbench
module pce_loader_tb;
	import pce_load_pkg::*;

	localparam logic [31:0] SEED = 32'ha920;
	// Cart load runs through the end of line 'h212
	localparam int CART_WORDS = 'h2130 / 2;
	localparam int SWAP_WORDS = 32;
	localparam int CODE_RECORDS = 2;
	localparam int CD_WORDS = 12;
	localparam int WORD_CYCLES = 12;
	localparam int CYCLE_LIMIT = (CART_WORDS + SWAP_WORDS) * WORD_CYCLES
		+ CODE_RECORDS * 8 * 2 + CD_WORDS * 5 + 1000;
	localparam logic [15:0] BAD_SIG_WORD = 16'h1234;

	logic clk_sys;
	logic reset;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic ioctl_wr;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [IOCTL_DATA_W-1:0] ioctl_dout;
	logic data_swap;
	logic mem_wr_ack;
	logic rom_wr_req;
	logic [ROM_ADDR_W-1:0] rom_addr;
	logic [IOCTL_DATA_W-1:0] rom_data;
	logic [11:0] rom_size;
	logic ioctl_wait;
	logic sgx;
	logic [1:0] populous;
	logic code_strobe;
	logic [CODE_WORD_W-1:0] code_flags;
	logic [CODE_WORD_W-1:0] code_addr;
	logic [CODE_WORD_W-1:0] code_compare;
	logic [CODE_WORD_W-1:0] code_replace;
	logic [7:0] cd_byte;
	logic cd_wr;
	logic cd_data_mode;

	logic [31:0] data_rng;
	logic [31:0] mem_rng = SEED;
	int cycles = 0;
	int tests_run;
	int tests_failed;
	int fails_before;

	clock_gen #(
		.PERIOD(10),
		.RESET_CYCLES(10)
	) clock_gen_i (
		.clk_sys(clk_sys),
		.reset(reset)
	);

	pce_loader_top pce_loader_top_i (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [15:0] signature_word(input logic [3:0] offset);
		case (offset)
			4'd6: return POP_SIG_0;
			4'd8: return POP_SIG_1;
			4'd10: return POP_SIG_2;
			default: return POP_SIG_3;
		endcase
	endfunction

	task automatic next_edge;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic draw_word(output logic [15:0] w);
		data_rng = xorshift32(data_rng);
		w = data_rng[15:0];
	endtask

	task automatic open_download(input logic [7:0] index, input logic swap);
		ioctl_index = index;
		data_swap = swap;
		ioctl_download = 1'b1;
		repeat (2) next_edge();
	endtask

	task automatic close_download;
		repeat (2) next_edge();
		ioctl_download = 1'b0;
		repeat (2) next_edge();
	endtask

	task automatic host_write(input logic [24:0] addr, input logic [15:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		next_edge();
		ioctl_wr = 1'b0;
	endtask

	// Host holds the next word until the back end has taken this one
	task automatic cart_word(input logic [24:0] addr, input logic [15:0] data);
		host_write(addr, data);
		while (ioctl_wait) begin
			next_edge();
		end
	endtask

	task automatic run_cart_load;
		logic [24:0] addr;
		logic [15:0] data;
		open_download(8'h00, 1'b0);
		for (int i = 0; i < CART_WORDS; i++) begin
			addr = 25'(i * 2);
			draw_word(data);
			if (addr[23:4] == POP_BANK0_LINE || addr[23:4] == POP_BANK1_LINE) begin
				if (addr[3:0] inside {4'd6, 4'd8, 4'd10, 4'd12}) begin
					data = signature_word(addr[3:0]);
				end
			end
			// One bad word in bank 0
			if (addr[23:4] == POP_BANK0_LINE && addr[3:0] == 4'd8) begin
				data = BAD_SIG_WORD;
			end
			cart_word(addr, data);
		end
		close_download();
	endtask

	task automatic run_swap_load;
		logic [15:0] data;
		open_download(8'h01, 1'b1);
		for (int i = 0; i < SWAP_WORDS; i++) begin
			draw_word(data);
			cart_word(25'(i * 2), data);
		end
		close_download();
	endtask

	task automatic run_cheat_codes;
		logic [15:0] data;
		open_download(8'hFF, 1'b0);
		for (int r = 0; r < CODE_RECORDS; r++) begin
			for (int s = 0; s < 8; s++) begin
				draw_word(data);
				host_write(25'(r * 16 + s * 2), data);
				next_edge();
			end
		end
		close_download();
	endtask

	// Words go out five cycles apart
	task automatic run_cd_stream(input logic [15:0] header, input int words);
		logic [15:0] data;
		open_download(8'h02, 1'b0);
		host_write('0, header);
		repeat (4) next_edge();
		for (int i = 0; i < words; i++) begin
			draw_word(data);
			host_write(25'(i * 2 + 2), data);
			repeat (4) next_edge();
		end
		close_download();
	endtask

	task automatic finish_test(input string name);
		int fails;
		fails = pce_loader_top_i.props_i.fail_count - fails_before;
		fails_before = pce_loader_top_i.props_i.fail_count;
		tests_run++;
		if (fails != 0) begin
			tests_failed++;
		end
		$display("test %s done: %0d assertion failures", name, fails);
	endtask

	////////////////////////////////////////
	// Memory back end
	////////////////////////////////////////

	initial begin
		int delay;
		mem_wr_ack = 1'b0;
		forever begin
			next_edge();
			if (!reset && rom_wr_req != mem_wr_ack) begin
				mem_rng = xorshift32(mem_rng);
				delay = int'(mem_rng[2:0]);
				repeat (delay) next_edge();
				mem_wr_ack = rom_wr_req;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run reached the cycle limit of %0d", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		data_swap = 1'b0;
		data_rng = SEED;
		tests_run = 0;
		tests_failed = 0;
		fails_before = 0;
		@(negedge reset);
		next_edge();
		finish_test("reset");
		run_cart_load();
		finish_test("cart load and signature");
		run_swap_load();
		finish_test("cart load with bit swap");
		run_cheat_codes();
		finish_test("cheat records");
		run_cd_stream(16'h8007, 5);
		finish_test("cd data, mode 1, odd length");
		run_cd_stream(16'h0004, 3);
		finish_test("cd data, mode 0, extra word");
		$display("%0d tests run, %0d with failures, %0d assertion failures in total",
			tests_run, tests_failed, fails_before);
		if (tests_failed == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
